// File: include/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// default number of tlb entries, a power of two.
`define MMU_TLB_ENTRIES 4

// 4 KiB pages.
`define MMU_PAGE_OFFSET_BITS 12

// exception vector codes.
`define MMU_EXC_PAGE_FAULT 3'd0
`define MMU_EXC_PRIV 3'd1

`endif

// File: hw/mmu_pkg.sv
`include "mmu_params.svh"

package mmu_pkg;

    // addresses on both sides of the translation.
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // page numbers, the address bits above the page offset.
    typedef logic [31-`MMU_PAGE_OFFSET_BITS:0] vpn_t;
    typedef logic [31-`MMU_PAGE_OFFSET_BITS:0] ppn_t;

    // exception code as seen by the trap logic.
    typedef logic [2:0] exc_vector_t;

endpackage

// File: hw/mmu_fault_if.sv
`timescale 1ns/1ns

interface mmu_fault_if import mmu_pkg::*; ();

    // user lookup with no matching entry.
    logic   miss;
    vaddr_t miss_addr;

    // tlb write attempted outside supervisor mode.
    logic   write_denied;
    vaddr_t denied_addr;

    modport reporter (
        output miss,
        output miss_addr,
        output write_denied,
        output denied_addr
    );

    modport collector (
        input miss,
        input miss_addr,
        input write_denied,
        input denied_addr
    );

endinterface

// File: hw/tlb.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module tlb import mmu_pkg::*; #(
    parameter int num_entries = `MMU_TLB_ENTRIES
) (
    input  logic          clk,
    input  logic          reset,

    // lookup side.
    input  logic          supervisor_mode,
    input  logic          lookup_valid,
    input  vaddr_t        virtual_address,

    // refill side.
    input  logic          write_enable,
    input  vaddr_t        write_virtual_address,
    input  paddr_t        write_physical_address,
    input  logic          flush,

    output paddr_t        physical_address,
    output logic          tlb_hit,

    mmu_fault_if.reporter fault
);

    localparam int ptr_bits = $clog2(num_entries);

    // entry storage.
    vpn_t                   tag [num_entries];
    ppn_t                   frame [num_entries];
    logic [num_entries-1:0] valid;
    logic [ptr_bits-1:0]    replace_ptr;

    vpn_t                   lookup_vpn;
    logic [num_entries-1:0] match;
    logic                   match_any;
    ppn_t                   match_frame;
    logic                   refill;

    assign lookup_vpn = virtual_address[31:`MMU_PAGE_OFFSET_BITS];

    // compare all tags in parallel.
    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            match[i] = valid[i] && (tag[i] == lookup_vpn);
        end
    end

    assign match_any = |match;

    // ascending scan, so the highest matching index wins.
    always_comb begin
        match_frame = '0;
        for (int i = 0; i < num_entries; i++) begin
            if (match[i]) begin
                match_frame = frame[i];
            end
        end
    end

    // supervisor mode bypasses translation.
    always_comb begin
        if (supervisor_mode) begin
            physical_address = virtual_address;
            tlb_hit          = 1'b1;
        end else if (match_any) begin
            physical_address = {match_frame, virtual_address[`MMU_PAGE_OFFSET_BITS-1:0]};
            tlb_hit          = 1'b1;
        end else begin
            physical_address = '0;
            tlb_hit          = 1'b0;
        end
    end

    // fault reports, one cycle wide, no acknowledge.
    assign fault.miss         = lookup_valid && !supervisor_mode && !match_any;
    assign fault.miss_addr    = virtual_address;
    assign fault.write_denied = write_enable && !supervisor_mode;
    assign fault.denied_addr  = write_virtual_address;

    // flush has priority over a refill in the same cycle.
    assign refill = write_enable && supervisor_mode && !flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid       <= '0;
            replace_ptr <= '0;
        end else if (flush) begin
            valid       <= '0;
            replace_ptr <= '0;
        end else if (refill) begin
            valid[replace_ptr] <= 1'b1;
            // wraps naturally, num_entries is a power of two.
            replace_ptr        <= replace_ptr + 1'b1;
        end
    end

    // tags and frames only matter once the valid bit is set.
    always_ff @(posedge clk) begin
        if (refill) begin
            tag[replace_ptr]   <= write_virtual_address[31:`MMU_PAGE_OFFSET_BITS];
            frame[replace_ptr] <= write_physical_address[31:`MMU_PAGE_OFFSET_BITS];
        end
    end

endmodule

// File: hw/mmu_fault_unit.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_fault_unit import mmu_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           fault_clear,

    mmu_fault_if.collector fault,

    output logic           fault_valid,
    output vaddr_t         fault_addr,
    output exc_vector_t    exception_vector,
    output logic           fault_overrun
);

    logic        new_fault;
    logic        capture;
    logic        overrun_set;
    vaddr_t      capture_addr;
    exc_vector_t capture_vector;

    assign new_fault = fault.miss || fault.write_denied;

    // privilege fault beats a page fault in the same cycle.
    always_comb begin
        if (fault.write_denied) begin
            capture_addr   = fault.denied_addr;
            capture_vector = `MMU_EXC_PRIV;
        end else begin
            capture_addr   = fault.miss_addr;
            capture_vector = `MMU_EXC_PAGE_FAULT;
        end
    end

    // register is free when empty or being cleared this cycle.
    assign capture     = new_fault && (!fault_valid || fault_clear);
    assign overrun_set = new_fault && fault_valid && !fault_clear;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_valid <= 1'b0;
        end else if (capture) begin
            fault_valid <= 1'b1;
        end else if (fault_clear) begin
            fault_valid <= 1'b0;
        end
    end

    // sticky until software clears it.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_overrun <= 1'b0;
        end else if (fault_clear) begin
            fault_overrun <= 1'b0;
        end else if (overrun_set) begin
            fault_overrun <= 1'b1;
        end
    end

    // first fault held, later ones dropped.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fault_addr       <= '0;
            exception_vector <= '0;
        end else if (capture) begin
            fault_addr       <= capture_addr;
            exception_vector <= capture_vector;
        end
    end

endmodule

// File: hw/mmu_top.sv
`timescale 1ns/1ns

module mmu_top import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        supervisor_mode,
    input  logic        lookup_valid,
    input  vaddr_t      virtual_address,

    input  logic        write_enable,
    input  vaddr_t      write_virtual_address,
    input  paddr_t      write_physical_address,
    input  logic        flush,

    input  logic        fault_clear,

    output paddr_t      physical_address,
    output logic        tlb_hit,

    output logic        fault_valid,
    output vaddr_t      fault_addr,
    output exc_vector_t exception_vector,
    output logic        fault_overrun
);

    // fault reports from the tlb to the capture register.
    mmu_fault_if fault_bus ();

    tlb u_tlb (
        .clk                    (clk),
        .reset                  (reset),
        .supervisor_mode        (supervisor_mode),
        .lookup_valid           (lookup_valid),
        .virtual_address        (virtual_address),
        .write_enable           (write_enable),
        .write_virtual_address  (write_virtual_address),
        .write_physical_address (write_physical_address),
        .flush                  (flush),
        .physical_address       (physical_address),
        .tlb_hit                (tlb_hit),
        .fault                  (fault_bus.reporter)
    );

    mmu_fault_unit u_fault_unit (
        .clk              (clk),
        .reset            (reset),
        .fault_clear      (fault_clear),
        .fault            (fault_bus.collector),
        .fault_valid      (fault_valid),
        .fault_addr       (fault_addr),
        .exception_vector (exception_vector),
        .fault_overrun    (fault_overrun)
    );

endmodule

// File: tb/mmu_properties.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_properties import mmu_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        supervisor_mode,
    input vaddr_t      virtual_address,
    input paddr_t      physical_address,
    input logic        tlb_hit,
    input logic        miss,
    input logic        write_denied,
    input logic        fault_valid,
    input exc_vector_t exception_vector
);

    // fault register comes out of reset empty.
    a_reset_empty: assert property (@(posedge clk) reset |=> !fault_valid)
        else $error("fault_valid high in the cycle after reset");

    // a capture needs a report one edge earlier.
    a_rise_after_report: assert property (@(posedge clk) disable iff (reset)
        $rose(fault_valid) |-> $past(miss || write_denied))
        else $error("fault_valid rose without a miss or denied write");

    // translation keeps the page offset.
    a_offset_kept: assert property (@(posedge clk) disable iff (reset)
        (!supervisor_mode && tlb_hit) |->
        physical_address[`MMU_PAGE_OFFSET_BITS-1:0] ==
        virtual_address[`MMU_PAGE_OFFSET_BITS-1:0])
        else $error("page offset changed by translation");

    a_vector_code: assert property (@(posedge clk) disable iff (reset)
        fault_valid |-> (exception_vector == `MMU_EXC_PAGE_FAULT ||
                         exception_vector == `MMU_EXC_PRIV))
        else $error("unknown exception vector while a fault is pending");

endmodule

bind mmu_top mmu_properties u_properties (
    .clk              (clk),
    .reset            (reset),
    .supervisor_mode  (supervisor_mode),
    .virtual_address  (virtual_address),
    .physical_address (physical_address),
    .tlb_hit          (tlb_hit),
    .miss             (fault_bus.miss),
    .write_denied     (fault_bus.write_denied),
    .fault_valid      (fault_valid),
    .exception_vector (exception_vector)
);

// File: tb/mmu_tb.sv
`timescale 1ns/1ns
`include "mmu_params.svh"

module mmu_tb import mmu_pkg::*; ();

    localparam int period          = 100;
    localparam int num_entries     = `MMU_TLB_ENTRIES;
    localparam int reset_cycles    = 5;
    localparam int directed_cycles = 100;
    localparam int random_steps    = 500;
    localparam int margin_cycles   = 100;
    localparam int total_cycles    = reset_cycles + directed_cycles + random_steps;

    logic        clk;
    logic        reset;
    logic        supervisor_mode;
    logic        lookup_valid;
    vaddr_t      virtual_address;
    logic        write_enable;
    vaddr_t      write_virtual_address;
    paddr_t      write_physical_address;
    logic        flush;
    logic        fault_clear;
    paddr_t      physical_address;
    logic        tlb_hit;
    logic        fault_valid;
    vaddr_t      fault_addr;
    exc_vector_t exception_vector;
    logic        fault_overrun;

    // shadow of the tlb entries and the fault register.
    vpn_t                   sh_tag [num_entries];
    ppn_t                   sh_frame [num_entries];
    logic [num_entries-1:0] sh_valid;
    int                     sh_ptr;
    logic                   exp_fault_valid;
    vaddr_t                 exp_fault_addr;
    exc_vector_t            exp_vector;
    logic                   exp_overrun;

    string       test_name = "reset";
    int          error_count = 0;
    logic [31:0] lfsr_state = 32'hfac7ff8f;

    mmu_top u_dut (
        .clk                    (clk),
        .reset                  (reset),
        .supervisor_mode        (supervisor_mode),
        .lookup_valid           (lookup_valid),
        .virtual_address        (virtual_address),
        .write_enable           (write_enable),
        .write_virtual_address  (write_virtual_address),
        .write_physical_address (write_physical_address),
        .flush                  (flush),
        .fault_clear            (fault_clear),
        .physical_address       (physical_address),
        .tlb_hit                (tlb_hit),
        .fault_valid            (fault_valid),
        .fault_addr             (fault_addr),
        .exception_vector       (exception_vector),
        .fault_overrun          (fault_overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] result;
        logic        feedback;
        result = '0;
        for (int i = 0; i < n; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            result     = {result[30:0], feedback};
        end
        return result;
    endfunction

    // eight pages from 0x00200, so lookups both hit and miss.
    function automatic vaddr_t pool_address();
        logic [31:0] page;
        logic [31:0] offset;
        page   = take_bits(3);
        offset = take_bits(12);
        return {17'h00040, page[2:0], offset[11:0]};
    endfunction

    // hit flag on top, physical address below.
    function automatic logic [32:0] expected_lookup(input logic sup, input vaddr_t va);
        logic hit;
        ppn_t frame;
        hit   = 1'b0;
        frame = '0;
        if (sup) begin
            return {1'b1, va};
        end
        // later index overrides, so the highest match wins.
        for (int i = 0; i < num_entries; i++) begin
            if (sh_valid[i] && sh_tag[i] == va[31:`MMU_PAGE_OFFSET_BITS]) begin
                hit   = 1'b1;
                frame = sh_frame[i];
            end
        end
        if (hit) begin
            return {1'b1, frame, va[`MMU_PAGE_OFFSET_BITS-1:0]};
        end
        return {1'b0, 32'h0};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // next state from the inputs the dut sees at the coming edge.
    task automatic update_model();
        logic [32:0] user_lookup;
        logic        miss;
        logic        denied;
        logic        new_fault;
        user_lookup = expected_lookup(1'b0, virtual_address);
        miss        = lookup_valid && !supervisor_mode && !user_lookup[32];
        denied      = write_enable && !supervisor_mode;
        new_fault   = miss || denied;
        if (fault_clear) begin
            exp_overrun = 1'b0;
        end else if (new_fault && exp_fault_valid) begin
            exp_overrun = 1'b1;
        end
        if (new_fault && (!exp_fault_valid || fault_clear)) begin
            exp_fault_valid = 1'b1;
            exp_fault_addr  = denied ? write_virtual_address : virtual_address;
            exp_vector      = denied ? `MMU_EXC_PRIV : `MMU_EXC_PAGE_FAULT;
        end else if (fault_clear) begin
            exp_fault_valid = 1'b0;
        end
        if (flush) begin
            sh_valid = '0;
            sh_ptr   = 0;
        end else if (write_enable && supervisor_mode) begin
            sh_tag[sh_ptr]   = write_virtual_address[31:`MMU_PAGE_OFFSET_BITS];
            sh_frame[sh_ptr] = write_physical_address[31:`MMU_PAGE_OFFSET_BITS];
            sh_valid[sh_ptr] = 1'b1;
            sh_ptr           = (sh_ptr + 1) % num_entries;
        end
    endtask

    // inputs are stable at the falling edge.
    always @(negedge clk) begin : compare
        logic [32:0] expected;
        if (reset !== 1'b0) begin
            sh_valid        = '0;
            sh_ptr          = 0;
            exp_fault_valid = 1'b0;
            exp_fault_addr  = '0;
            exp_vector      = '0;
            exp_overrun     = 1'b0;
        end else begin
            expected = expected_lookup(supervisor_mode, virtual_address);
            compare_value("tlb_hit", 32'(expected[32]), 32'(tlb_hit));
            compare_value("physical_address", expected[31:0], physical_address);
            compare_value("fault_valid", 32'(exp_fault_valid), 32'(fault_valid));
            compare_value("fault_addr", exp_fault_addr, fault_addr);
            compare_value("exception_vector", 32'(exp_vector), 32'(exception_vector));
            compare_value("fault_overrun", 32'(exp_overrun), 32'(fault_overrun));
            update_model();
        end
    end

    initial begin
        #((total_cycles + margin_cycles) * period);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog: the tests did not finish in the expected time");
    end

    // one clock cycle of stimulus.
    task automatic apply_step(input logic sup, input logic lv, input vaddr_t va,
                              input logic we, input vaddr_t wva, input paddr_t wpa,
                              input logic fl, input logic clr);
        @(posedge clk);
        supervisor_mode        <= sup;
        lookup_valid           <= lv;
        virtual_address        <= va;
        write_enable           <= we;
        write_virtual_address  <= wva;
        write_physical_address <= wpa;
        flush                  <= fl;
        fault_clear            <= clr;
    endtask

    task automatic idle();
        apply_step(1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic do_lookup(input logic sup, input vaddr_t va);
        apply_step(sup, 1'b1, va, 1'b0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic do_write(input logic sup, input vaddr_t wva, input paddr_t wpa);
        apply_step(sup, 1'b0, '0, 1'b1, wva, wpa, 1'b0, 1'b0);
    endtask

    task automatic do_clear();
        apply_step(1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b0, 1'b1);
    endtask

    task automatic expect_translation(input paddr_t exp_pa, input logic exp_hit);
        @(negedge clk);
        compare_value("tlb_hit", 32'(exp_hit), 32'(tlb_hit));
        compare_value("physical_address", exp_pa, physical_address);
    endtask

    task automatic expect_fault(input logic exp_valid, input vaddr_t exp_addr,
                                input exc_vector_t exp_vec, input logic exp_ovr);
        @(negedge clk);
        compare_value("fault_valid", 32'(exp_valid), 32'(fault_valid));
        compare_value("fault_overrun", 32'(exp_ovr), 32'(fault_overrun));
        if (exp_valid) begin
            compare_value("fault_addr", exp_addr, fault_addr);
            compare_value("exception_vector", 32'(exp_vec), 32'(exception_vector));
        end
    endtask

    initial begin
        reset                  <= 1'b1;
        supervisor_mode        <= 1'b0;
        lookup_valid           <= 1'b0;
        virtual_address        <= '0;
        write_enable           <= 1'b0;
        write_virtual_address  <= '0;
        write_physical_address <= '0;
        flush                  <= 1'b0;
        fault_clear            <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        test_name = "bypass";
        do_lookup(1'b1, 32'h1234_5678);
        expect_translation(32'h1234_5678, 1'b1);
        do_lookup(1'b1, 32'hffff_f001);
        expect_translation(32'hffff_f001, 1'b1);

        // one page more than the tlb holds, so page 0x00040 is evicted.
        test_name = "refill";
        for (int i = 0; i <= num_entries; i++) begin
            do_write(1'b1, 32'h0004_0000 + (i << 12), 32'h8000_0000 + (i << 12));
        end
        for (int i = 1; i <= num_entries; i++) begin
            do_lookup(1'b0, 32'h0004_0123 + (i << 12));
            expect_translation(32'h8000_0123 + (i << 12), 1'b1);
        end
        do_lookup(1'b0, 32'h0004_0010);
        expect_translation(32'h0, 1'b0);
        do_clear();

        test_name = "page_fault";
        do_lookup(1'b0, 32'h0009_9555);
        idle();
        expect_fault(1'b1, 32'h0009_9555, `MMU_EXC_PAGE_FAULT, 1'b0);
        repeat (3) idle();
        expect_fault(1'b1, 32'h0009_9555, `MMU_EXC_PAGE_FAULT, 1'b0);
        do_clear();
        idle();
        expect_fault(1'b0, '0, '0, 1'b0);

        // denied write together with a miss.
        test_name = "privilege";
        apply_step(1'b0, 1'b1, 32'h0009_9000, 1'b1, 32'h0007_7abc, 32'hdead_b000, 1'b0, 1'b0);
        idle();
        expect_fault(1'b1, 32'h0007_7abc, `MMU_EXC_PRIV, 1'b0);
        do_clear();
        do_lookup(1'b0, 32'h0007_7abc);
        expect_translation(32'h0, 1'b0);
        do_clear();

        test_name = "overrun";
        do_lookup(1'b0, 32'h0001_1111);
        do_lookup(1'b0, 32'h0002_2222);
        idle();
        expect_fault(1'b1, 32'h0001_1111, `MMU_EXC_PAGE_FAULT, 1'b1);
        apply_step(1'b0, 1'b1, 32'h0003_3333, 1'b0, '0, '0, 1'b0, 1'b1);
        idle();
        expect_fault(1'b1, 32'h0003_3333, `MMU_EXC_PAGE_FAULT, 1'b0);
        do_clear();
        idle();
        expect_fault(1'b0, '0, '0, 1'b0);

        test_name = "flush";
        do_write(1'b1, 32'h0005_5000, 32'h9000_0000);
        do_write(1'b1, 32'h0006_6000, 32'h9100_0000);
        do_lookup(1'b0, 32'h0005_5010);
        expect_translation(32'h9000_0010, 1'b1);
        apply_step(1'b0, 1'b0, '0, 1'b0, '0, '0, 1'b1, 1'b0);
        do_lookup(1'b0, 32'h0005_5010);
        expect_translation(32'h0, 1'b0);
        do_lookup(1'b0, 32'h0006_6020);
        expect_translation(32'h0, 1'b0);
        do_clear();
        // flush beats a refill in the same cycle.
        apply_step(1'b1, 1'b0, '0, 1'b1, 32'h0007_7000, 32'h9200_0000, 1'b1, 1'b0);
        do_lookup(1'b0, 32'h0007_7000);
        expect_translation(32'h0, 1'b0);
        do_clear();
        // entry 0 gets this page, the second copy in entry 1 wins as the higher index.
        do_write(1'b1, 32'h0008_8000, 32'ha000_0000);
        do_write(1'b1, 32'h0008_8000, 32'ha100_0000);
        do_lookup(1'b0, 32'h0008_8000);
        expect_translation(32'ha100_0000, 1'b1);
        // a full round evicts both copies.
        for (int i = 0; i < num_entries; i++) begin
            do_write(1'b1, 32'h000b_0000 + (i << 12), 32'hb000_0000 + (i << 12));
        end
        do_lookup(1'b0, 32'h0008_8000);
        expect_translation(32'h0, 1'b0);
        do_clear();

        test_name = "random";
        for (int i = 0; i < random_steps; i++) begin
            apply_step(take_bits(2) == 32'd0, take_bits(1) == 32'd1, pool_address(),
                       take_bits(2) == 32'd0, pool_address(), take_bits(32),
                       take_bits(5) == 32'd0, take_bits(3) == 32'd0);
        end
        idle();
        idle();
        @(posedge clk);

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: all.f
+incdir+include
hw/mmu_pkg.sv
hw/mmu_fault_if.sv
hw/tlb.sv
hw/mmu_fault_unit.sv
hw/mmu_top.sv
tb/mmu_properties.sv
tb/mmu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mmu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
